/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = cn_relay_tb
FILELIST  = cn_relay.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "SIM FAILED"; exit 1; \
	elif grep -q "Finished with no errors" $(LOG); then echo "SIM PASSED"; \
	else echo "SIM FAILED: no result in log"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cn_relay.f */
src/cn_relay_pkg.sv
src/synapse_current.sv
src/sensory_path.sv
src/gain_button_ctrl.sv
src/cfg_regs.sv
src/drive_combiner.sv
src/cn_neuron.sv
src/cn_relay_top.sv
verif/cn_relay_sva.sv
verif/cn_relay_tb.sv

/* src/cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs #(
    parameter int unsigned RESET_THRESHOLD = 30720  // 30 << 10
) (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_cfg_req,   // four-phase request from host
    input  cn_relay_pkg::cfg_req_t   i_cfg,       // stable while req is high
    output logic                     o_cfg_ack,
    output cn_relay_pkg::cfg_state_t o_cfg
);

    logic                   ack_q;
    logic                   apply;        // new request seen this cycle
    logic                   release_ack;  // host dropped req after our ack
    cn_relay_pkg::current_t extra_drive_q;
    cn_relay_pkg::current_t threshold_q;
    logic                   clear_q;

    // req high and ack low is the only point a request is taken,
    // ack stays high until req drops so one req pulse applies once
    assign apply       = i_cfg_req && !ack_q;
    assign release_ack = !i_cfg_req && ack_q;

    // handshake flop
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            ack_q <= 1'b0;
        end else if (apply) begin
            ack_q <= 1'b1;   // phase 2
        end else if (release_ack) begin
            ack_q <= 1'b0;   // phase 4
        end
    end

    // register file, written on the same edge that raises ack
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            extra_drive_q <= '0;
            threshold_q   <= cn_relay_pkg::current_t'(RESET_THRESHOLD);
            clear_q       <= 1'b0;
        end else begin
            clear_q <= 1'b0;  // pulse lasts one cycle only
            if (apply) begin
                case (i_cfg.op)
                    cn_relay_pkg::CFG_EXTRA_DRIVE: begin
                        extra_drive_q <= i_cfg.data;
                    end
                    cn_relay_pkg::CFG_THRESHOLD: begin
                        threshold_q <= i_cfg.data;
                    end
                    cn_relay_pkg::CFG_CLEAR_COUNT: begin
                        clear_q <= 1'b1;  // nothing stored, data ignored
                    end
                    default: begin
                        // unused opcode, acked but no effect
                    end
                endcase
            end
        end
    end

    assign o_cfg_ack         = ack_q;
    assign o_cfg.extra_drive = extra_drive_q;
    assign o_cfg.threshold   = threshold_q;
    assign o_cfg.clear_count = clear_q;

endmodule

/* src/cn_neuron.sv */
`timescale 1ns/1ps

module cn_neuron #(
    parameter int unsigned LEAK_SHIFT = 4  // leak is v/2^LEAK_SHIFT per step
) (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  cn_relay_pkg::current_t i_drive,        // latched input current
    input  cn_relay_pkg::current_t i_threshold,
    input  logic                   i_clear_count,  // wins over an increment
    output logic                   o_spike,        // high one cycle per firing
    output cn_relay_pkg::current_t o_spike_count
);

    cn_relay_pkg::current_t potential_q;
    cn_relay_pkg::current_t leak;
    cn_relay_pkg::current_t potential_d;  // candidate before the threshold test
    logic                   fire;
    logic                   spike_q;
    cn_relay_pkg::current_t count_q;

    assign leak = potential_q >> LEAK_SHIFT;

    // integrate and leak in one step
    assign potential_d = potential_q + i_drive - leak;

    // threshold compare on the new value
    assign fire = (potential_d >= i_threshold);

    // membrane and spike flag
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            potential_q <= '0;
            spike_q     <= 1'b0;
        end else if (fire) begin
            potential_q <= '0;    // reset to rest after firing
            spike_q     <= 1'b1;
        end else begin
            potential_q <= potential_d;
            spike_q     <= 1'b0;
        end
    end

    // spike counter
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            count_q <= '0;
        end else if (i_clear_count) begin
            count_q <= '0;               // a spike in this cycle is dropped
        end else if (fire) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign o_spike       = spike_q;
    assign o_spike_count = count_q;

endmodule

/* src/cn_relay_pkg.sv */
package cn_relay_pkg;

    // datapath widths
    localparam int CUR_W  = 32;  // currents, potential, threshold, spike count
    localparam int GAIN_W = 4;   // button prescaler and scaler

    // unsigned fixed point current or membrane potential
    typedef logic [CUR_W-1:0] current_t;

    // host configuration opcodes
    typedef enum logic [1:0] {
        CFG_EXTRA_DRIVE = 2'd0,  // load extra cortical drive
        CFG_THRESHOLD   = 2'd1,  // load firing threshold
        CFG_CLEAR_COUNT = 2'd2   // zero the spike counter, data ignored
    } cfg_op_e;

    // one request on the config port
    // host keeps it stable while req is high
    typedef struct packed {
        cfg_op_e  op;    // what to update
        current_t data;  // payload for drive / threshold
    } cfg_req_t;

    // state the config slave hands to the datapath
    typedef struct packed {
        current_t extra_drive;  // added straight into the drive sum
        current_t threshold;    // neuron fires at or above this
        logic     clear_count;  // one cycle pulse
    } cfg_state_t;

endpackage

/* src/cn_relay_top.sv */
`timescale 1ns/1ps

module cn_relay_top #(
    parameter int unsigned SYN_WEIGHT      = 100,
    parameter int unsigned DECAY_SHIFT     = 3,
    parameter int unsigned COMP_SHIFT      = 9,
    parameter int unsigned LEAK_SHIFT      = 4,
    parameter int unsigned RESET_THRESHOLD = 30720  // 30 << 10
) (
    input  logic                            ep50trig,      // one simulation step per edge
    input  logic                            reset_global,
    input  logic                            i_spike_ia,
    input  logic                            i_spike_ii,
    input  logic                            i_button,
    input  logic                            i_cfg_req,
    input  cn_relay_pkg::cfg_req_t          i_cfg,
    output logic                            o_cfg_ack,
    output cn_relay_pkg::current_t          o_drive,
    output logic [cn_relay_pkg::GAIN_W-1:0] o_scaler,
    output logic                            o_spike,
    output cn_relay_pkg::current_t          o_spike_count
);

    cn_relay_pkg::current_t          sensory;  // compensated afferent current
    logic [cn_relay_pkg::GAIN_W-1:0] scaler;
    cn_relay_pkg::cfg_state_t        cfg;
    cn_relay_pkg::current_t          drive;

    sensory_path #(
        .SYN_WEIGHT  (SYN_WEIGHT),
        .DECAY_SHIFT (DECAY_SHIFT),
        .COMP_SHIFT  (COMP_SHIFT)
    ) u_sensory_path (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike_ia   (i_spike_ia),
        .i_spike_ii   (i_spike_ii),
        .o_sensory    (sensory)
    );

    gain_button_ctrl u_gain_button_ctrl (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_button     (i_button),
        .o_scaler     (scaler)
    );

    cfg_regs #(
        .RESET_THRESHOLD (RESET_THRESHOLD)
    ) u_cfg_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_req    (i_cfg_req),
        .i_cfg        (i_cfg),
        .o_cfg_ack    (o_cfg_ack),
        .o_cfg        (cfg)
    );

    drive_combiner u_drive_combiner (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sensory     (sensory),
        .i_scaler      (scaler),
        .i_extra_drive (cfg.extra_drive),
        .o_drive       (drive)
    );

    // relay cell
    cn_neuron #(
        .LEAK_SHIFT (LEAK_SHIFT)
    ) u_cn_neuron (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_drive       (drive),
        .i_threshold   (cfg.threshold),
        .i_clear_count (cfg.clear_count),
        .o_spike       (o_spike),
        .o_spike_count (o_spike_count)
    );

    assign o_drive  = drive;   // latched drive also seen by the host
    assign o_scaler = scaler;

endmodule

/* src/drive_combiner.sv */
`timescale 1ns/1ps

module drive_combiner (
    input  logic                            ep50trig,
    input  logic                            reset_global,
    input  cn_relay_pkg::current_t          i_sensory,      // compensated afferent current
    input  logic [cn_relay_pkg::GAIN_W-1:0] i_scaler,       // button gain 0..7
    input  cn_relay_pkg::current_t          i_extra_drive,  // host cortical drive
    output cn_relay_pkg::current_t          o_drive
);

    cn_relay_pkg::current_t scaler_ext;    // scaler widened to datapath
    cn_relay_pkg::current_t sensory_gain;  // gain scaled copy
    cn_relay_pkg::current_t drive_sum;
    cn_relay_pkg::current_t drive_q;

    assign scaler_ext = cn_relay_pkg::current_t'(i_scaler);

    // product kept at datapath width, upper bits dropped
    assign sensory_gain = i_sensory * scaler_ext;

    // base current always passes, gain adds on top of it
    assign drive_sum = i_sensory + sensory_gain + i_extra_drive;

    // latch once per step so the neuron integrates a steady value
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            drive_q <= '0;
        end else begin
            drive_q <= drive_sum;
        end
    end

    assign o_drive = drive_q;

endmodule

/* src/gain_button_ctrl.sv */
`timescale 1ns/1ps

module gain_button_ctrl (
    input  logic                            ep50trig,
    input  logic                            reset_global,
    input  logic                            i_button,   // toggles once per press, async
    output logic [cn_relay_pkg::GAIN_W-1:0] o_scaler    // 0..7 sensory gain step
);

    localparam logic [cn_relay_pkg::GAIN_W-1:0] PRESCALE_MAX = 4'd14;  // wraps after this

    logic                            sync1;
    logic                            sync2;
    logic                            level_change;
    logic [cn_relay_pkg::GAIN_W-1:0] prescaler;

    // two flop synchronizer for the button level
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
        end else begin
            sync1 <= i_button;
            sync2 <= sync1;
        end
    end

    // any edge of the button counts, rising or falling
    assign level_change = sync1 ^ sync2;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            prescaler <= '0;
        end else if (level_change) begin
            if (prescaler == PRESCALE_MAX) begin
                prescaler <= '0;  // 14 -> 0, scaler goes 7 -> 0
            end else begin
                prescaler <= prescaler + 1'b1;
            end
        end
    end

    // two toggles per gain step
    assign o_scaler = prescaler >> 1;

endmodule

/* src/sensory_path.sv */
`timescale 1ns/1ps

module sensory_path #(
    parameter int unsigned SYN_WEIGHT  = 100,
    parameter int unsigned DECAY_SHIFT = 3,
    parameter int unsigned COMP_SHIFT  = 9   // neuron compensation gain, 2^COMP_SHIFT
) (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   i_spike_ia,  // primary spindle afferent
    input  logic                   i_spike_ii,  // secondary spindle afferent
    output cn_relay_pkg::current_t o_sensory
);

    cn_relay_pkg::current_t current_ia;
    cn_relay_pkg::current_t current_ii;
    cn_relay_pkg::current_t current_sum;

    // Ia synapse
    synapse_current #(
        .SYN_WEIGHT  (SYN_WEIGHT),
        .DECAY_SHIFT (DECAY_SHIFT)
    ) u_syn_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (i_spike_ia),
        .o_current    (current_ia)
    );

    // II synapse, same weight and time constant as Ia
    synapse_current #(
        .SYN_WEIGHT  (SYN_WEIGHT),
        .DECAY_SHIFT (DECAY_SHIFT)
    ) u_syn_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (i_spike_ii),
        .o_current    (current_ii)
    );

    assign current_sum = current_ia + current_ii;  // both afferents onto one cell

    // scale up before the relay neuron, same cycle as the sum
    // top bits fall off if the sum is large, values are kept small in practice
    assign o_sensory = current_sum << COMP_SHIFT;

endmodule

/* src/synapse_current.sv */
`timescale 1ns/1ps

module synapse_current #(
    parameter int unsigned SYN_WEIGHT  = 100,  // jump per afferent spike
    parameter int unsigned DECAY_SHIFT = 3     // decay rate is 1/2^DECAY_SHIFT per step
) (
    input  logic                   ep50trig,
    input  logic                   reset_global,
    input  logic                   i_spike,    // one afferent spike per high cycle
    output cn_relay_pkg::current_t o_current
);

    cn_relay_pkg::current_t current_q;
    cn_relay_pkg::current_t decay;   // amount lost this step
    cn_relay_pkg::current_t kick;    // amount gained this step
    cn_relay_pkg::current_t current_d;

    // geometric decay, integer form of the exponential synapse
    assign decay = current_q >> DECAY_SHIFT;

    assign kick = i_spike ? cn_relay_pkg::current_t'(SYN_WEIGHT)
                          : '0;  // no spike, no weight term

    // decay never exceeds the current itself so no underflow here
    assign current_d = current_q - decay + kick;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            current_q <= '0;
        end else begin
            current_q <= current_d;  // one simulation step per clock
        end
    end

    assign o_current = current_q;

endmodule

/* verif/cn_relay_sva.sv */
`timescale 1ns/1ps

module cn_relay_sva (
    input logic                            ep50trig,
    input logic                            reset_global,
    input logic                            i_cfg_req,
    input logic                            o_cfg_ack,
    input logic [cn_relay_pkg::GAIN_W-1:0] i_prescaler
);

    // ack can only go up while the host holds req
    ack_rise_with_req: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (!o_cfg_ack && !i_cfg_req) |=> !o_cfg_ack
    ) else $error("cfg ack rose with req low");

    // ack can only go down once req is gone
    ack_fall_without_req: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_cfg_ack && i_cfg_req) |=> o_cfg_ack
    ) else $error("cfg ack fell with req high");

    // prescaler stays in 0..14 so the halved scaler stays in 0..7
    prescaler_range: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_prescaler <= 4'd14
    ) else $error("gain prescaler above 14");

endmodule

bind cn_relay_top cn_relay_sva u_cn_relay_sva (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_cfg_req    (i_cfg_req),
    .o_cfg_ack    (o_cfg_ack),
    .i_prescaler  (u_gain_button_ctrl.prescaler)
);

/* verif/cn_relay_tb.sv */
`timescale 1ns/1ps

module cn_relay_tb;

    localparam int unsigned SYN_WEIGHT      = 100;
    localparam int unsigned DECAY_SHIFT     = 3;
    localparam int unsigned COMP_SHIFT      = 9;
    localparam int unsigned LEAK_SHIFT      = 4;
    localparam int unsigned RESET_THRESHOLD = 30720;
    localparam int          NUM_PHASES      = 9;
    localparam int          MARGIN          = 50;  // slack on top of the table length

    // one stimulus row
    typedef struct packed {
        logic [31:0]            ia_pat;      // bit c%32 is the Ia spike in cycle c
        logic [31:0]            ii_pat;
        logic                   rnd;         // random spikes instead of the patterns
        logic [4:0]             toggles;     // button toggles spaced 4 cycles apart
        logic                   cfg_en;      // one config write at phase start
        cn_relay_pkg::cfg_op_e  op;
        cn_relay_pkg::current_t data;
        logic [15:0]            len;         // phase length in cycles
        logic [3:0]             exp_scaler;  // o_scaler at phase end
    } phase_t;

    logic                            ep50trig;
    logic                            reset_global;
    logic                            i_spike_ia;
    logic                            i_spike_ii;
    logic                            i_button;
    logic                            i_cfg_req;
    cn_relay_pkg::cfg_req_t          i_cfg;
    logic                            o_cfg_ack;
    cn_relay_pkg::current_t          o_drive;
    logic [cn_relay_pkg::GAIN_W-1:0] o_scaler;
    logic                            o_spike;
    cn_relay_pkg::current_t          o_spike_count;

    phase_t      phases [NUM_PHASES];
    phase_t      ph;
    int          hs_step;        // 0 idle, 1 raise req, 2 wait ack, 3 wait ack low
    int          error_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 1000;
    logic [31:0] rnd_word;

    // reference model state
    cn_relay_pkg::current_t m_cur_ia = '0;
    cn_relay_pkg::current_t m_cur_ii = '0;
    logic                   m_sync1 = 1'b0;
    logic                   m_sync2 = 1'b0;
    logic [3:0]             m_prescale = '0;
    logic                   m_ack = 1'b0;
    cn_relay_pkg::current_t m_extra = '0;
    cn_relay_pkg::current_t m_thr = cn_relay_pkg::current_t'(RESET_THRESHOLD);
    logic                   m_clear = 1'b0;
    cn_relay_pkg::current_t m_drive = '0;
    cn_relay_pkg::current_t m_pot = '0;
    logic                   m_spike = 1'b0;
    cn_relay_pkg::current_t m_count = '0;
    cn_relay_pkg::current_t m_sens;
    cn_relay_pkg::current_t m_pot_next;
    logic                   m_fire;
    logic                   m_apply;

    cn_relay_top #(
        .SYN_WEIGHT      (SYN_WEIGHT),
        .DECAY_SHIFT     (DECAY_SHIFT),
        .COMP_SHIFT      (COMP_SHIFT),
        .LEAK_SHIFT      (LEAK_SHIFT),
        .RESET_THRESHOLD (RESET_THRESHOLD)
    ) u_cn_relay_top (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spike_ia    (i_spike_ia),
        .i_spike_ii    (i_spike_ii),
        .i_button      (i_button),
        .i_cfg_req     (i_cfg_req),
        .i_cfg         (i_cfg),
        .o_cfg_ack     (o_cfg_ack),
        .o_drive       (o_drive),
        .o_scaler      (o_scaler),
        .o_spike       (o_spike),
        .o_spike_count (o_spike_count)
    );

    always #50 ep50trig = ~ep50trig;  // 100 ns step

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic phase_t make_phase(input logic [31:0] ia, input logic [31:0] ii,
                                          input logic rnd, input int toggles,
                                          input logic cfg_en, input cn_relay_pkg::cfg_op_e op,
                                          input int unsigned data, input int len,
                                          input int exp_scaler);
        phase_t r;
        r.ia_pat     = ia;
        r.ii_pat     = ii;
        r.rnd        = rnd;
        r.toggles    = 5'(toggles);
        r.cfg_en     = cfg_en;
        r.op         = op;
        r.data       = cn_relay_pkg::current_t'(data);
        r.len        = 16'(len);
        r.exp_scaler = 4'(exp_scaler);
        return r;
    endfunction

    // cycle model of decay, sum, shift, gain, latch and integrate and fire
    always @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            m_cur_ia <= '0;
            m_cur_ii <= '0;
            m_sync1 <= 1'b0;
            m_sync2 <= 1'b0;
            m_prescale <= '0;
            m_ack <= 1'b0;
            m_extra <= '0;
            m_thr <= cn_relay_pkg::current_t'(RESET_THRESHOLD);
            m_clear <= 1'b0;
            m_drive <= '0;
            m_pot <= '0;
            m_spike <= 1'b0;
            m_count <= '0;
        end else begin
            m_sens = (m_cur_ia + m_cur_ii) << COMP_SHIFT;  // compensated current
            m_pot_next = m_pot + m_drive - (m_pot >> LEAK_SHIFT);
            m_fire = (m_pot_next >= m_thr);
            m_apply = i_cfg_req && !m_ack;
            m_cur_ia <= m_cur_ia - (m_cur_ia >> DECAY_SHIFT)
                        + (i_spike_ia ? cn_relay_pkg::current_t'(SYN_WEIGHT) : '0);
            m_cur_ii <= m_cur_ii - (m_cur_ii >> DECAY_SHIFT)
                        + (i_spike_ii ? cn_relay_pkg::current_t'(SYN_WEIGHT) : '0);
            m_sync1 <= i_button;
            m_sync2 <= m_sync1;
            if (m_sync1 != m_sync2)
                m_prescale <= (m_prescale == 4'd14) ? 4'd0 : m_prescale + 4'd1;  // wraps
            m_drive <= m_sens
                       + m_sens * cn_relay_pkg::current_t'(m_prescale >> 1) + m_extra;
            m_pot <= m_fire ? '0 : m_pot_next;
            m_spike <= m_fire;
            if (m_clear)
                m_count <= '0;  // clear beats a spike
            else if (m_fire)
                m_count <= m_count + 32'd1;
            m_clear <= m_apply && (i_cfg.op == cn_relay_pkg::CFG_CLEAR_COUNT);
            if (m_apply)
                m_ack <= 1'b1;
            else if (!i_cfg_req && m_ack)
                m_ack <= 1'b0;
            if (m_apply && i_cfg.op == cn_relay_pkg::CFG_EXTRA_DRIVE)
                m_extra <= i_cfg.data;
            if (m_apply && i_cfg.op == cn_relay_pkg::CFG_THRESHOLD)
                m_thr <= i_cfg.data;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge ep50trig) begin
        if (!reset_global) begin
            check_value("o_drive", 64'(o_drive), 64'(m_drive));
            check_value("o_scaler", 64'(o_scaler), 64'(m_prescale >> 1));
            check_value("o_spike", 64'(o_spike), 64'(m_spike));
            check_value("o_spike_count", 64'(o_spike_count), 64'(m_count));
            check_value("o_cfg_ack", 64'(o_cfg_ack), 64'(m_ack));
        end
    end

    always @(posedge ep50trig) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("run did not end within %0d cycles", timeout_limit);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    initial begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_spike_ia   = 1'b0;
        i_spike_ii   = 1'b0;
        i_button     = 1'b0;
        i_cfg_req    = 1'b0;
        i_cfg        = '0;
        void'($urandom(58211));
        phases[0] = make_phase(0, 0, 0, 0, 0, cn_relay_pkg::CFG_EXTRA_DRIVE, 0, 20, 0);  // idle
        phases[1] = make_phase(32'h0000_0111, 0, 0, 0, 0, cn_relay_pkg::CFG_EXTRA_DRIVE,
                               0, 64, 0);  // Ia only
        phases[2] = make_phase(0, 32'h0101_0003, 0, 0, 0, cn_relay_pkg::CFG_EXTRA_DRIVE,
                               0, 64, 0);  // II only
        phases[3] = make_phase(0, 0, 1, 0, 0, cn_relay_pkg::CFG_EXTRA_DRIVE, 0, 64, 0);
        phases[4] = make_phase(32'h1111_1111, 0, 0, 6, 0, cn_relay_pkg::CFG_EXTRA_DRIVE,
                               0, 40, 3);  // prescaler 6
        phases[5] = make_phase(32'h1111_1111, 0, 0, 9, 0, cn_relay_pkg::CFG_EXTRA_DRIVE,
                               0, 48, 0);  // 15 toggles in all wrap the prescaler to 0
        phases[6] = make_phase(0, 0, 0, 0, 1, cn_relay_pkg::CFG_EXTRA_DRIVE, 5000, 40, 0);
        phases[7] = make_phase(0, 0, 0, 0, 1, cn_relay_pkg::CFG_THRESHOLD, 40000, 60, 0);
        phases[8] = make_phase(0, 0, 0, 0, 1, cn_relay_pkg::CFG_CLEAR_COUNT, 0, 40, 0);
        timeout_limit = 3 + MARGIN;
        for (int p = 0; p < NUM_PHASES; p++)
            timeout_limit += int'(phases[p].len);

        repeat (3) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);
        check_value("o_drive", 64'(o_drive), 64'd0);  // reset values
        check_value("o_scaler", 64'(o_scaler), 64'd0);
        check_value("o_spike", 64'(o_spike), 64'd0);
        check_value("o_spike_count", 64'(o_spike_count), 64'd0);
        check_value("o_cfg_ack", 64'(o_cfg_ack), 64'd0);

        for (int p = 0; p < NUM_PHASES; p++) begin
            ph = phases[p];
            hs_step = ph.cfg_en ? 1 : 0;
            for (int c = 0; c < int'(ph.len); c++) begin
                @(posedge ep50trig);
                rnd_word = $urandom();
                i_spike_ia <= ph.rnd ? rnd_word[0] : ph.ia_pat[c[4:0]];
                i_spike_ii <= ph.rnd ? rnd_word[1] : ph.ii_pat[c[4:0]];
                if (c < int'(ph.toggles) * 4 && c % 4 == 0)
                    i_button <= ~i_button;
                case (hs_step)
                    1: begin
                        i_cfg     <= '{op: ph.op, data: ph.data};
                        i_cfg_req <= 1'b1;
                        hs_step = 2;
                    end
                    2: if (o_cfg_ack) begin  // value from before this edge
                        i_cfg_req <= 1'b0;
                        hs_step = 3;
                    end
                    3: if (!o_cfg_ack) hs_step = 0;
                    default: ;
                endcase
            end
            @(negedge ep50trig);
            if (hs_step != 0) begin
                $display("config handshake in phase %0d did not complete", p);
                $display("Finished with errors");
                $fatal(1, "handshake stuck");
            end
            check_value("o_scaler", 64'(o_scaler), 64'(ph.exp_scaler));
            if (p == 7)
                check_value("o_spike_count_nonzero", 64'(o_spike_count != 0), 64'd1);
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
